// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_core_pkg.sv
      - logic/rv_register_file.sv
      - logic/rv_pipe_reg.sv
      - logic/rv_decode.sv
      - logic/rv_execute.sv
      - logic/rv_result.sv
      - logic/rv_core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_rv_core.sv

// ==== logic/rv_core.sv ====
//////////////////////////////////////////////////////////////////////
// Top level of the core: decode, execute and result steps with two
// pipeline registers and the register file, two cycles of latency
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_core (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        instr_valid_i,
  input  rv_core_pkg::word_t          instr_i,
  output logic                        wb_valid_o,
  output logic                        wb_we_o,
  output rv_core_pkg::reg_addr_t      wb_rd_o,
  output rv_core_pkg::word_t          wb_data_o,
  output logic                        illegal_o,
  output logic [`RV_RETIRE_CNT_W-1:0] retired_o
);
  import rv_core_pkg::*;

  // Register file
  reg_addr_t rf_raddr_a;
  reg_addr_t rf_raddr_b;
  word_t     rf_rdata_a;
  word_t     rf_rdata_b;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  // Decode to execute
  logic      id_ex_valid;
  id_ex_t    id_ex_data;
  logic      id_ex_valid_q;
  id_ex_t    id_ex_data_q;

  // Execute to result
  logic      ex_fwd_we;
  ex_wb_t    ex_wb_data;
  logic      ex_wb_valid_q;
  ex_wb_t    ex_wb_data_q;

  rv_register_file register_file_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////
  rv_decode decode_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    // Execute forward
    .fwd_ex_we_i   (ex_fwd_we),
    .fwd_ex_rd_i   (ex_wb_data.rd),
    .fwd_ex_data_i (ex_wb_data.result),
    // Result forward
    .fwd_wb_we_i   (rf_we),
    .fwd_wb_rd_i   (rf_waddr),
    .fwd_wb_data_i (rf_wdata),
    .id_ex_valid_o (id_ex_valid),
    .id_ex_data_o  (id_ex_data)
  );

  rv_pipe_reg #(.payload_t(id_ex_t)) id_ex_reg_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (id_ex_valid),
    .data_i  (id_ex_data),
    .valid_o (id_ex_valid_q),
    .data_o  (id_ex_data_q)
  );

  //////////////////////////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////////////////////////
  rv_execute execute_i (
    .valid_i  (id_ex_valid_q),
    .id_ex_i  (id_ex_data_q),
    .fwd_we_o (ex_fwd_we),
    .ex_wb_o  (ex_wb_data)
  );

  // Valid goes straight on from the first register
  rv_pipe_reg #(.payload_t(ex_wb_t)) ex_wb_reg_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (id_ex_valid_q),
    .data_i  (ex_wb_data),
    .valid_o (ex_wb_valid_q),
    .data_o  (ex_wb_data_q)
  );

  //////////////////////////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////////////////////////
  rv_result result_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (ex_wb_valid_q),
    .ex_wb_i    (ex_wb_data_q),
    .rf_we_o    (rf_we),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata),
    .wb_valid_o (wb_valid_o),
    .wb_we_o    (wb_we_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o),
    .illegal_o  (illegal_o),
    .retired_o  (retired_o)
  );

endmodule

// ==== logic/rv_core_params.svh ====
//////////////////////////////////////////////////////////////////////
// Width, opcode and counter constants for the three-step RV32I core
// Included by the package and by every module that needs a constant
//////////////////////////////////////////////////////////////////////

`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Datapath and register file
`define RV_XLEN          32
`define RV_NUM_REGS      32
`define RV_REG_ADDR_W    5

// Accepted major opcodes
`define RV_OPC_OP        7'b0110011
`define RV_OPC_OP_IMM    7'b0010011
`define RV_OPC_LUI       7'b0110111

// Retired instruction counter
`define RV_RETIRE_CNT_W  32

`endif

// ==== logic/rv_core_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types of the core: data word, register index, ALU operation
// and the two payloads that travel through the pipeline registers
//////////////////////////////////////////////////////////////////////

`include "rv_core_params.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0]       word_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

  // ALU operations, PASS_B serves LUI
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // Decode to execute, 75 bits
  typedef struct packed {
    alu_op_e   op;
    word_t     opa;
    word_t     opb;
    reg_addr_t rd;
    logic      we;
    logic      illegal;
  } id_ex_t;

  // Execute to result, 39 bits
  typedef struct packed {
    word_t     result;
    reg_addr_t rd;
    logic      we;
    logic      illegal;
  } ex_wb_t;

endpackage

// ==== logic/rv_decode.sv ====
//////////////////////////////////////////////////////////////////////
// Decode step with field split, operation select, immediates, operand
// read with forwarding from execute and result, and illegal detection
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_decode (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   instr_valid_i,
  input  rv_core_pkg::word_t     instr_i,
  // Register file read
  output rv_core_pkg::reg_addr_t rf_raddr_a_o,
  output rv_core_pkg::reg_addr_t rf_raddr_b_o,
  input  rv_core_pkg::word_t     rf_rdata_a_i,
  input  rv_core_pkg::word_t     rf_rdata_b_i,
  // Forward from execute
  input  logic                   fwd_ex_we_i,
  input  rv_core_pkg::reg_addr_t fwd_ex_rd_i,
  input  rv_core_pkg::word_t     fwd_ex_data_i,
  // Forward from result
  input  logic                   fwd_wb_we_i,
  input  rv_core_pkg::reg_addr_t fwd_wb_rd_i,
  input  rv_core_pkg::word_t     fwd_wb_data_i,
  // To first pipeline register
  output logic                   id_ex_valid_o,
  output rv_core_pkg::id_ex_t    id_ex_data_o
);
  import rv_core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  word_t      imm_i;
  word_t      imm_u;
  word_t      rs1_val;
  word_t      rs2_val;
  alu_op_e    op;
  logic       is_op;
  logic       is_op_imm;
  logic       is_lui;
  logic       f7_zero;
  logic       f7_alt;
  logic       f7_ok;
  logic       illegal;

  // Instruction fields
  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  assign is_op     = (opcode == `RV_OPC_OP);
  assign is_op_imm = (opcode == `RV_OPC_OP_IMM);
  assign is_lui    = (opcode == `RV_OPC_LUI);
  assign f7_zero   = (funct7 == 7'b0000000);
  assign f7_alt    = (funct7 == 7'b0100000);

  // Sign-extended I and U immediates
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};

  ////////////////////////////////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    op    = ALU_ADD;
    f7_ok = 1'b1;
    case (funct3)
      // Only OP uses the SUB encoding
      3'b000: begin
        op    = (is_op && f7_alt) ? ALU_SUB : ALU_ADD;
        f7_ok = is_op_imm || f7_zero || f7_alt;
      end
      3'b001: begin
        op    = ALU_SLL;
        f7_ok = f7_zero;
      end
      3'b010: begin
        op    = ALU_SLT;
        f7_ok = is_op_imm || f7_zero;
      end
      3'b011: begin
        op    = ALU_SLTU;
        f7_ok = is_op_imm || f7_zero;
      end
      3'b100: begin
        op    = ALU_XOR;
        f7_ok = is_op_imm || f7_zero;
      end
      // Shift right where funct7 picks arithmetic in both groups
      3'b101: begin
        op    = f7_alt ? ALU_SRA : ALU_SRL;
        f7_ok = f7_zero || f7_alt;
      end
      3'b110: begin
        op    = ALU_OR;
        f7_ok = is_op_imm || f7_zero;
      end
      default: begin
        op    = ALU_AND;
        f7_ok = is_op_imm || f7_zero;
      end
    endcase
    // LUI ignores funct3 and funct7
    if (is_lui) begin
      op    = ALU_PASS_B;
      f7_ok = 1'b1;
    end
  end

  assign illegal = !(is_op || is_op_imm || is_lui) || !f7_ok;

  ////////////////////////////////////////////////////////////////////
  // Operand read and forwarding
  ////////////////////////////////////////////////////////////////////
  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;

  // Newest value wins, execute before result before register file
  assign rs1_val = (fwd_ex_we_i && (fwd_ex_rd_i == rs1)) ? fwd_ex_data_i :
                   (fwd_wb_we_i && (fwd_wb_rd_i == rs1)) ? fwd_wb_data_i :
                   rf_rdata_a_i;
  assign rs2_val = (fwd_ex_we_i && (fwd_ex_rd_i == rs2)) ? fwd_ex_data_i :
                   (fwd_wb_we_i && (fwd_wb_rd_i == rs2)) ? fwd_wb_data_i :
                   rf_rdata_b_i;

  // Payload
  assign id_ex_valid_o = instr_valid_i;

  always_comb begin
    id_ex_data_o.op      = op;
    id_ex_data_o.opa     = rs1_val;
    id_ex_data_o.opb     = is_op ? rs2_val : (is_lui ? imm_u : imm_i);
    id_ex_data_o.rd      = rd;
    // No write for illegal encodings or x0
    id_ex_data_o.we      = !illegal && (rd != '0);
    id_ex_data_o.illegal = illegal;
  end

  // An execute forward to x0 would corrupt every read of x0
  a_fwd_ex_no_x0 : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fwd_ex_we_i |-> (fwd_ex_rd_i != '0));

endmodule

// ==== logic/rv_execute.sv ====
//////////////////////////////////////////////////////////////////////
// Execute step: combinational ALU over the decoded operands
// Its result also feeds the forwarding path back into decode
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_execute (
  input  logic                valid_i,
  input  rv_core_pkg::id_ex_t id_ex_i,
  // Forwarding write-enable, rd and data come from ex_wb_o
  output logic                fwd_we_o,
  output rv_core_pkg::ex_wb_t ex_wb_o
);
  import rv_core_pkg::*;

  word_t      opa;
  word_t      opb;
  logic [4:0] shamt;
  word_t      result;

  assign opa   = id_ex_i.opa;
  assign opb   = id_ex_i.opb;
  // Only the low five bits shift
  assign shamt = opb[4:0];

  ////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    case (id_ex_i.op)
      ALU_ADD:    result = opa + opb;
      ALU_SUB:    result = opa - opb;
      ALU_SLL:    result = opa << shamt;
      // Compares give 0 or 1
      ALU_SLT:    result = {31'b0, $signed(opa) < $signed(opb)};
      ALU_SLTU:   result = {31'b0, opa < opb};
      ALU_XOR:    result = opa ^ opb;
      ALU_SRL:    result = opa >> shamt;
      ALU_SRA:    result = $signed(opa) >>> shamt;
      ALU_OR:     result = opa | opb;
      ALU_AND:    result = opa & opb;
      // LUI immediate straight through
      ALU_PASS_B: result = opb;
      default:    result = '0;
    endcase
  end

  // Destination and flags copied through
  always_comb begin
    ex_wb_o.result  = result;
    ex_wb_o.rd      = id_ex_i.rd;
    ex_wb_o.we      = id_ex_i.we;
    ex_wb_o.illegal = id_ex_i.illegal;
  end

  // Stale payload must not forward
  assign fwd_we_o = valid_i && id_ex_i.we;

endmodule

// ==== logic/rv_pipe_reg.sv ====
//////////////////////////////////////////////////////////////////////
// Pipeline register with a valid bit, for any payload type
// Sits between decode and execute, and between execute and result
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  // Valid bit, cleared on reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Payload only moves with a valid beat
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_o <= data_i;
    end
  end

  // Downstream qualifies everything with valid_o
  a_valid_known : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(valid_o));

endmodule

// ==== logic/rv_register_file.sv ====
//////////////////////////////////////////////////////////////////////
// Integer register file, two combinational reads and one write
// x0 is not stored and always reads as zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_register_file (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Read ports
  input  rv_core_pkg::reg_addr_t raddr_a_i,
  input  rv_core_pkg::reg_addr_t raddr_b_i,
  output rv_core_pkg::word_t     rdata_a_o,
  output rv_core_pkg::word_t     rdata_b_o,
  // Write port
  input  logic                  we_i,
  input  rv_core_pkg::reg_addr_t waddr_i,
  input  rv_core_pkg::word_t     wdata_i
);
  import rv_core_pkg::*;

  // Only x1..x31 have storage
  word_t regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Index 0 reads zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

  // Result step must never request a write to x0
  a_no_x0_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> (waddr_i != '0));

endmodule

// ==== logic/rv_result.sv ====
//////////////////////////////////////////////////////////////////////
// Result step with the register file write, the write-back ports and
// the count of retired instructions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_result (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        valid_i,
  input  rv_core_pkg::ex_wb_t         ex_wb_i,
  // Register file write port
  output logic                        rf_we_o,
  output rv_core_pkg::reg_addr_t      rf_waddr_o,
  output rv_core_pkg::word_t          rf_wdata_o,
  // Write-back ports
  output logic                        wb_valid_o,
  output logic                        wb_we_o,
  output rv_core_pkg::reg_addr_t      wb_rd_o,
  output rv_core_pkg::word_t          wb_data_o,
  output logic                        illegal_o,
  output logic [`RV_RETIRE_CNT_W-1:0] retired_o
);

  // Write only for a valid legal beat
  assign rf_we_o    = valid_i && ex_wb_i.we && !ex_wb_i.illegal;
  assign rf_waddr_o = ex_wb_i.rd;
  assign rf_wdata_o = ex_wb_i.result;

  assign wb_valid_o = valid_i;
  assign wb_we_o    = rf_we_o;
  assign wb_rd_o    = ex_wb_i.rd;
  assign wb_data_o  = ex_wb_i.result;
  assign illegal_o  = valid_i && ex_wb_i.illegal;

  // Retire counter, legal instructions only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      retired_o <= '0;
    end else if (valid_i && !ex_wb_i.illegal) begin
      retired_o <= retired_o + 1'b1;
    end
  end

  // Illegal beat arrives without a write request
  a_illegal_no_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    illegal_o |-> !ex_wb_i.we);

endmodule

// ==== testbench/tb_rv_core.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the three-step RV32I core
// Applies a stimulus table one instruction per cycle, runs a register
// model in program order and checks every write-back strobe against it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "rv_core_params.svh"

module tb_rv_core;
  import rv_core_pkg::*;

  // Cycles allowed for the pipeline to empty at the end
  localparam int DRAIN_LIMIT = 10;

  // One expected write-back
  typedef struct {
    reg_addr_t rd;
    word_t     data;
    logic      we;
    logic      ill;
    int        issue;
  } expect_t;

  logic                        clk_i;
  logic                        rst_n_i;
  logic                        instr_valid_i;
  word_t                       instr_i;
  logic                        wb_valid_o;
  logic                        wb_we_o;
  reg_addr_t                   wb_rd_o;
  word_t                       wb_data_o;
  logic                        illegal_o;
  logic [`RV_RETIRE_CNT_W-1:0] retired_o;

  // Stimulus table
  // An entry with valid low is a bubble
  word_t                       stim_instr [$];
  logic                        stim_valid [$];
  // Model registers and write-backs still in flight
  word_t                       model_regs [`RV_NUM_REGS];
  expect_t                     exp_q [$];
  logic [`RV_RETIRE_CNT_W-1:0] legal_cnt;
  logic [31:0]                 lfsr_q;
  // Falling edges since reset release
  int                          cycle;

  rv_core dut0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_we_o       (wb_we_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .illegal_o     (illegal_o),
    .retired_o     (retired_o)
  );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  //////////////////////////////////////////////////////////////////////
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_word(input word_t act, input word_t exp, input string what);
    if (act !== exp) begin
      stop_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, act, exp));
    end
  endtask

  task automatic check_reg_addr(input reg_addr_t act, input reg_addr_t exp, input string what);
    if (act !== exp) begin
      stop_run($sformatf("Error at %0t ns: %s is x%0d, expected x%0d", $time, what, act, exp));
    end
  endtask

  task automatic check_flag(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      stop_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, act, exp));
    end
  endtask

  task automatic check_count(input logic [`RV_RETIRE_CNT_W-1:0] act,
                             input logic [`RV_RETIRE_CNT_W-1:0] exp, input string what);
    if (act !== exp) begin
      stop_run($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, what, act, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Random bits and instruction encoders
  //////////////////////////////////////////////////////////////////////
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic word_t op_word(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
  endfunction

  function automatic word_t imm_word(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, `RV_OPC_OP_IMM};
  endfunction

  function automatic word_t lui_word(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, `RV_OPC_LUI};
  endfunction

  task automatic add_instr(input word_t ins);
    stim_instr.push_back(ins);
    stim_valid.push_back(1'b1);
  endtask

  task automatic add_bubble();
    stim_instr.push_back('0);
    stim_valid.push_back(1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////
  task automatic build_table();
    logic [31:0] v;
    // Untouched registers read back as zero
    for (int i = 1; i < 5; i++) begin
      add_instr(imm_word(12'h000, reg_addr_t'(i * 7), 3'b000, reg_addr_t'(i)));
    end
    // Immediate group and LUI with random immediates
    for (int r = 0; r < 3; r++) begin
      take_bits(20, v);
      add_instr(lui_word(v[19:0], 5'd3));
      take_bits(12, v);
      add_instr(imm_word(v[11:0], 5'd3, 3'b000, 5'd4));
      for (int f = 2; f < 8; f++) begin
        if (f != 5) begin
          take_bits(12, v);
          add_instr(imm_word(v[11:0], 5'd4, 3'(f), 5'(13 + f)));
        end
      end
      take_bits(5, v);
      add_instr(imm_word({7'h00, v[4:0]}, 5'd4, 3'b001, 5'd21));
      take_bits(5, v);
      add_instr(imm_word({7'h00, v[4:0]}, 5'd4, 3'b101, 5'd22));
      take_bits(5, v);
      add_instr(imm_word({7'h20, v[4:0]}, 5'd4, 3'b101, 5'd23));
    end
    // Negative operands in x5 and x6
    add_instr(lui_word(20'h80001, 5'd5));
    add_instr(imm_word(12'hffb, 5'd0, 3'b000, 5'd6));
    add_instr(imm_word(12'h7ff, 5'd5, 3'b000, 5'd5));
    for (int f = 0; f < 8; f++) begin
      add_instr(op_word(7'h00, 5'd6, 5'd5, 3'(f), 5'(24 + f)));
    end
    add_instr(op_word(7'h20, 5'd6, 5'd5, 3'b000, 5'd24));
    add_instr(op_word(7'h20, 5'd5, 5'd6, 3'b101, 5'd25));
    add_instr(op_word(7'h00, 5'd5, 5'd6, 3'b010, 5'd26));
    add_instr(op_word(7'h00, 5'd5, 5'd6, 3'b011, 5'd27));
    // Chain on x7 at distance 1
    // Both forwards hit the same register on the last add
    add_instr(imm_word(12'h001, 5'd0, 3'b000, 5'd7));
    for (int i = 0; i < 3; i++) begin
      add_instr(op_word(7'h00, 5'd7, 5'd7, 3'b000, 5'd7));
    end
    // x8 at distance 2 and x9 at distance 1
    add_instr(imm_word(12'h003, 5'd0, 3'b000, 5'd8));
    add_instr(imm_word(12'h004, 5'd0, 3'b000, 5'd9));
    add_instr(op_word(7'h00, 5'd9, 5'd8, 3'b000, 5'd10));
    add_instr(op_word(7'h20, 5'd8, 5'd10, 3'b000, 5'd11));
    // Distance 2 across a bubble
    add_instr(imm_word(12'h009, 5'd0, 3'b000, 5'd12));
    add_bubble();
    add_instr(imm_word(12'h001, 5'd12, 3'b000, 5'd13));
    // x0 stays zero
    add_instr(imm_word(12'h005, 5'd0, 3'b000, 5'd0));
    add_instr(op_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd14));
    // Undefined opcode and bad funct7 in both groups
    add_instr(32'hffff_ffff);
    add_instr(op_word(7'h01, 5'd2, 5'd1, 3'b000, 5'd14));
    add_instr(imm_word({7'h20, 5'd1}, 5'd1, 3'b001, 5'd14));
    // x14 untouched by the illegal ones
    add_instr(imm_word(12'h001, 5'd14, 3'b000, 5'd1));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model for one instruction in program order
  //////////////////////////////////////////////////////////////////////
  task automatic model_apply(input word_t ins, output expect_t e);
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      r;
    logic       legal;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    a   = model_regs[ins[19:15]];
    b   = (opc == `RV_OPC_OP) ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    if (opc == `RV_OPC_OP) begin
      legal = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
    end else if (opc == `RV_OPC_OP_IMM) begin
      legal = (f3 == 3'd1) ? (f7 == 7'h00) :
              ((f3 != 3'd5) || (f7 == 7'h00) || (f7 == 7'h20));
    end else begin
      legal = (opc == `RV_OPC_LUI);
    end
    case (f3)
      3'd0: r = (opc == `RV_OPC_OP && f7[5]) ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (f7[5]) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    if (opc == `RV_OPC_LUI) begin
      r = {ins[31:12], 12'h000};
    end
    e.rd    = ins[11:7];
    e.data  = r;
    e.we    = legal && (ins[11:7] != '0);
    e.ill   = !legal;
    e.issue = 0;
    if (e.we) begin
      model_regs[e.rd] = r;
    end
    if (legal) begin
      legal_cnt = legal_cnt + 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Per-cycle sample and drive on the falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic sample_outputs();
    expect_t e;
    cycle++;
    if (wb_valid_o) begin
      if (exp_q.size() == 0) begin
        stop_run($sformatf("Write-back strobe at %0t ns with no instruction in flight",
                           $time));
      end else begin
        e = exp_q.pop_front();
        if (cycle != e.issue + 2) begin
          stop_run($sformatf("Error at %0t ns: write-back %0d cycles after issue, expected 2",
                             $time, cycle - e.issue));
        end else begin
          check_reg_addr(wb_rd_o, e.rd, "wb_rd_o");
          check_flag(wb_we_o, e.we, "wb_we_o");
          check_flag(illegal_o, e.ill, "illegal_o");
          // Data of an illegal beat is don't care
          if (!e.ill) begin
            check_word(wb_data_o, e.data, "wb_data_o");
          end
        end
      end
    end else begin
      check_flag(illegal_o, 1'b0, "illegal_o without write-back strobe");
      if (exp_q.size() != 0 && cycle > exp_q[0].issue + 2) begin
        stop_run($sformatf("Write-back missing at %0t ns for an instruction issued %0d cycles ago",
                           $time, cycle - exp_q[0].issue));
      end
    end
  endtask

  task automatic drive_entry(input int idx);
    expect_t e;
    instr_valid_i = stim_valid[idx];
    instr_i       = stim_instr[idx];
    if (stim_valid[idx]) begin
      model_apply(stim_instr[idx], e);
      e.issue = cycle;
      exp_q.push_back(e);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    int wait_cnt;
    rst_n_i       = 1'b0;
    // Illegal beat held during reset must never reach the ports
    instr_valid_i = 1'b1;
    instr_i       = 32'hffff_ffff;
    lfsr_q        = 32'h33794d05;
    legal_cnt     = '0;
    cycle         = 0;
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    build_table();

    // Reset held over 8 rising edges and released on a falling edge
    repeat (8) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    rst_n_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    check_flag(wb_valid_o, 1'b0, "wb_valid_o after reset");
    check_flag(illegal_o, 1'b0, "illegal_o after reset");
    check_count(retired_o, '0, "retired_o after reset");

    // One table entry per cycle
    for (int i = 0; i < stim_instr.size(); i++) begin
      @(negedge clk_i);
      sample_outputs();
      drive_entry(i);
    end

    // Let the pipeline empty
    wait_cnt = 0;
    while (exp_q.size() != 0) begin
      if (wait_cnt == DRAIN_LIMIT) begin
        stop_run("Timeout while waiting for the last write-backs to arrive");
      end else begin
        @(negedge clk_i);
        sample_outputs();
        instr_valid_i = 1'b0;
        wait_cnt++;
      end
    end

    // Counter moves at the edge after the last strobe
    @(negedge clk_i);
    sample_outputs();
    check_count(retired_o, legal_cnt, "retired_o at end");
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/rv_core_pkg.sv
logic/rv_register_file.sv
logic/rv_pipe_reg.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core.sv
testbench/tb_rv_core.sv
